// ==== axi_csr.f ====
rtl/axi_bus_pkg.sv
rtl/csr_map_pkg.sv
rtl/axi_sub_frontend.sv
rtl/csr_access_adapter.sv
rtl/csr_regfile.sv
rtl/axi_csr_top.sv
verif/axi_csr_tb.sv

// ==== rtl/axi_bus_pkg.sv ====
// AXI field widths, response encoding and the transaction request/response structs
package axi_bus_pkg;

  localparam int unsigned AxiAddrWidth = 32;
  localparam int unsigned AxiDataWidth = 64;
  localparam int unsigned AxiIdWidth   = 8;
  localparam int unsigned AxiUserWidth = 32;
  localparam int unsigned AxiStrbWidth = AxiDataWidth / 8;

  // Entries in the privileged user ID list
  localparam int unsigned NumPrivIds = 4;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axi_resp_e;

  // One captured single-beat transaction
  typedef struct packed {
    logic                    write;
    logic [AxiAddrWidth-1:0] addr;
    logic [AxiIdWidth-1:0]   id;
    logic [AxiUserWidth-1:0] user;
    logic [AxiDataWidth-1:0] wdata;
    logic [AxiStrbWidth-1:0] wstrb;
  } bus_req_t;

  // Result handed back to the frontend
  typedef struct packed {
    logic [AxiDataWidth-1:0] rdata;
    logic                    err;
  } bus_rsp_t;

endpackage

// ==== rtl/axi_csr_top.sv ====
// AXI-lite CSR block top level: frontend, access adapter and register file
`timescale 1ns/1ps

module axi_csr_top import axi_bus_pkg::*, csr_map_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_ni,

  input  logic [AxiAddrWidth-1:0] araddr_i,
  input  logic [AxiIdWidth-1:0]   arid_i,
  input  logic [AxiUserWidth-1:0] aruser_i,
  input  logic                    arvalid_i,
  output logic                    arready_o,

  output logic [AxiDataWidth-1:0] rdata_o,
  output axi_resp_e               rresp_o,
  output logic [AxiIdWidth-1:0]   rid_o,
  output logic                    rlast_o,
  output logic                    rvalid_o,
  input  logic                    rready_i,

  input  logic [AxiAddrWidth-1:0] awaddr_i,
  input  logic [AxiIdWidth-1:0]   awid_i,
  input  logic [AxiUserWidth-1:0] awuser_i,
  input  logic                    awvalid_i,
  output logic                    awready_o,

  input  logic [AxiDataWidth-1:0] wdata_i,
  input  logic [AxiStrbWidth-1:0] wstrb_i,
  input  logic                    wvalid_i,
  output logic                    wready_o,

  output axi_resp_e               bresp_o,
  output logic [AxiIdWidth-1:0]   bid_o,
  output logic                    bvalid_o,
  input  logic                    bready_i,

  input  logic                    filter_disable_i,
  input  logic [AxiUserWidth-1:0] priv_ids_i [NumPrivIds]
);

  logic     req_valid;
  bus_req_t bus_req;
  logic     rsp_valid;
  bus_rsp_t bus_rsp;
  csr_req_t csr_req;
  csr_rsp_t csr_rsp;

  axi_sub_frontend u_frontend (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .araddr_i   (araddr_i),
    .arid_i     (arid_i),
    .aruser_i   (aruser_i),
    .arvalid_i  (arvalid_i),
    .arready_o  (arready_o),
    .rdata_o    (rdata_o),
    .rresp_o    (rresp_o),
    .rid_o      (rid_o),
    .rlast_o    (rlast_o),
    .rvalid_o   (rvalid_o),
    .rready_i   (rready_i),
    .awaddr_i   (awaddr_i),
    .awid_i     (awid_i),
    .awuser_i   (awuser_i),
    .awvalid_i  (awvalid_i),
    .awready_o  (awready_o),
    .wdata_i    (wdata_i),
    .wstrb_i    (wstrb_i),
    .wvalid_i   (wvalid_i),
    .wready_o   (wready_o),
    .bresp_o    (bresp_o),
    .bid_o      (bid_o),
    .bvalid_o   (bvalid_o),
    .bready_i   (bready_i),
    .req_valid_o(req_valid),
    .req_o      (bus_req),
    .rsp_valid_i(rsp_valid),
    .rsp_i      (bus_rsp)
  );

  csr_access_adapter u_adapter (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_valid_i     (req_valid),
    .req_i           (bus_req),
    .rsp_valid_o     (rsp_valid),
    .rsp_o           (bus_rsp),
    .filter_disable_i(filter_disable_i),
    .priv_ids_i      (priv_ids_i),
    .csr_req_o       (csr_req),
    .csr_rsp_i       (csr_rsp)
  );

  csr_regfile u_regfile (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .csr_req_i(csr_req),
    .csr_rsp_o(csr_rsp)
  );

endmodule

// ==== rtl/axi_sub_frontend.sv ====
// AXI-lite subordinate channel handshakes with single-transaction capture and response hold
`timescale 1ns/1ps

module axi_sub_frontend import axi_bus_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_ni,

  input  logic [AxiAddrWidth-1:0] araddr_i,
  input  logic [AxiIdWidth-1:0]   arid_i,
  input  logic [AxiUserWidth-1:0] aruser_i,
  input  logic                    arvalid_i,
  output logic                    arready_o,

  output logic [AxiDataWidth-1:0] rdata_o,
  output axi_resp_e               rresp_o,
  output logic [AxiIdWidth-1:0]   rid_o,
  output logic                    rlast_o,
  output logic                    rvalid_o,
  input  logic                    rready_i,

  input  logic [AxiAddrWidth-1:0] awaddr_i,
  input  logic [AxiIdWidth-1:0]   awid_i,
  input  logic [AxiUserWidth-1:0] awuser_i,
  input  logic                    awvalid_i,
  output logic                    awready_o,

  input  logic [AxiDataWidth-1:0] wdata_i,
  input  logic [AxiStrbWidth-1:0] wstrb_i,
  input  logic                    wvalid_i,
  output logic                    wready_o,

  output axi_resp_e               bresp_o,
  output logic [AxiIdWidth-1:0]   bid_o,
  output logic                    bvalid_o,
  input  logic                    bready_i,

  output logic                    req_valid_o,
  output bus_req_t                req_o,
  input  logic                    rsp_valid_i,
  input  bus_rsp_t                rsp_i
);

  typedef enum logic [1:0] {
    IDLE,
    BUSY,
    RESP_R,
    RESP_W
  } fe_state_e;

  fe_state_e state_q, state_d;

  bus_req_t                req_q, req_d;
  logic [AxiDataWidth-1:0] rdata_q;
  axi_resp_e               resp_q;

  logic idle;
  logic wr_take;
  logic rd_take;

  assign idle = (state_q == IDLE);

  // AW waits for its W beat, write beats a concurrent read
  assign awready_o = idle & ~(awvalid_i & ~wvalid_i);
  assign wready_o  = idle & awvalid_i;
  assign arready_o = idle & ~(awvalid_i & wvalid_i);

  assign wr_take = idle & awvalid_i & wvalid_i;
  assign rd_take = arvalid_i & arready_o;

  always_comb begin
    req_d = '0;
    if (wr_take) begin
      req_d.write = 1'b1;
      req_d.addr  = awaddr_i;
      req_d.id    = awid_i;
      req_d.user  = awuser_i;
      req_d.wdata = wdata_i;
      req_d.wstrb = wstrb_i;
    end else begin
      req_d.addr = araddr_i;
      req_d.id   = arid_i;
      req_d.user = aruser_i;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (wr_take || rd_take) begin
          state_d = BUSY;
        end
      end
      BUSY: begin
        if (rsp_valid_i) begin
          state_d = req_q.write ? RESP_W : RESP_R;
        end
      end
      RESP_R: begin
        if (rready_i) begin
          state_d = IDLE;
        end
      end
      RESP_W: begin
        if (bready_i) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_take || rd_take) begin
      req_q <= req_d;
    end
    if (state_q == BUSY && rsp_valid_i) begin
      rdata_q <= rsp_i.rdata;
      resp_q  <= rsp_i.err ? RESP_SLVERR : RESP_OKAY;
    end
  end

  assign req_valid_o = (state_q == BUSY);
  assign req_o       = req_q;

  assign rvalid_o = (state_q == RESP_R);
  assign rdata_o  = rdata_q;
  assign rresp_o  = resp_q;
  assign rid_o    = req_q.id;
  assign rlast_o  = 1'b1;

  assign bvalid_o = (state_q == RESP_W);
  assign bresp_o  = resp_q;
  assign bid_o    = req_q.id;

endmodule

// ==== rtl/csr_access_adapter.sv ====
// Privileged ID filter, lane selection and CSR request/acknowledge sequencing
`timescale 1ns/1ps

module csr_access_adapter import axi_bus_pkg::*, csr_map_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_ni,

  input  logic                    req_valid_i,
  input  bus_req_t                req_i,
  output logic                    rsp_valid_o,
  output bus_rsp_t                rsp_o,

  input  logic                    filter_disable_i,
  input  logic [AxiUserWidth-1:0] priv_ids_i [NumPrivIds],

  output csr_req_t                csr_req_o,
  input  csr_rsp_t                csr_rsp_i
);

  logic [NumPrivIds-1:0]   id_hit;
  logic                    legal;
  logic                    pending_q;
  logic                    strobe;
  logic                    ack;
  logic                    lane;
  logic [CsrDataWidth-1:0] lane_wdata;
  logic [CsrStrbWidth-1:0] lane_wstrb;
  logic [CsrDataWidth-1:0] lane_biten;

  always_comb begin
    for (int i = 0; i < NumPrivIds; i++) begin
      id_hit[i] = (req_i.user == priv_ids_i[i]);
    end
  end

  assign legal = filter_disable_i | (|id_hit);

  // One strobe per legal request, held off while the ack is outstanding
  assign strobe = req_valid_i & legal & ~pending_q;
  assign ack    = pending_q & (csr_rsp_i.rd_ack | csr_rsp_i.wr_ack);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q <= 1'b0;
    end else if (strobe) begin
      pending_q <= 1'b1;
    end else if (ack) begin
      pending_q <= 1'b0;
    end
  end

  assign lane       = req_i.addr[CsrLaneBit];
  assign lane_wdata = req_i.wdata[lane*CsrDataWidth +: CsrDataWidth];
  assign lane_wstrb = req_i.wstrb[lane*CsrStrbWidth +: CsrStrbWidth];

  always_comb begin
    for (int i = 0; i < CsrStrbWidth; i++) begin
      lane_biten[i*8 +: 8] = {8{lane_wstrb[i]}};
    end
  end

  always_comb begin
    csr_req_o          = '0;
    csr_req_o.req      = strobe;
    csr_req_o.wr       = req_i.write;
    csr_req_o.addr     = req_i.addr[CsrAddrWidth-1:0];
    csr_req_o.wr_data  = lane_wdata;
    csr_req_o.wr_biten = req_i.write ? lane_biten : '0;
  end

  // Illegal IDs are answered at once without touching the register file
  assign rsp_valid_o = (req_valid_i & ~legal) | ack;

  always_comb begin
    rsp_o       = '0;
    rsp_o.err   = ~legal | csr_rsp_i.err;
    if (legal) begin
      rsp_o.rdata[lane*CsrDataWidth +: CsrDataWidth] = csr_rsp_i.rd_data;
    end
  end

endmodule

// ==== rtl/csr_map_pkg.sv ====
// CSR register map, CSR widths, lane select bit and register constants
package csr_map_pkg;

  localparam int unsigned CsrAddrWidth = 12;
  localparam int unsigned CsrDataWidth = 32;
  localparam int unsigned CsrStrbWidth = CsrDataWidth / 8;

  // Address bit picking the 32-bit lane of the 64-bit bus
  localparam int unsigned CsrLaneBit = 2;

  localparam int unsigned NumScratch = 4;

  localparam logic [CsrDataWidth-1:0] CsrVersion   = 32'h0001_0300;
  localparam logic [CsrDataWidth-1:0] ScratchReset = 32'h0000_0000;

  typedef enum logic [CsrAddrWidth-1:0] {
    CSR_SCRATCH0 = 12'h000,
    CSR_SCRATCH1 = 12'h004,
    CSR_SCRATCH2 = 12'h008,
    CSR_SCRATCH3 = 12'h00C,
    CSR_VERSION  = 12'h010,
    CSR_WR_COUNT = 12'h014
  } csr_addr_e;

  typedef struct packed {
    logic                    req;
    logic                    wr;
    logic [CsrAddrWidth-1:0] addr;
    logic [CsrDataWidth-1:0] wr_data;
    logic [CsrDataWidth-1:0] wr_biten;
  } csr_req_t;

  typedef struct packed {
    logic                    rd_ack;
    logic                    wr_ack;
    logic                    err;
    logic [CsrDataWidth-1:0] rd_data;
  } csr_rsp_t;

endpackage

// ==== rtl/csr_regfile.sv ====
// Scratch, version and write counter registers behind a CSR request/acknowledge port
`timescale 1ns/1ps

module csr_regfile import csr_map_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  csr_req_t csr_req_i,
  output csr_rsp_t csr_rsp_o
);

  localparam int unsigned ScratchIdxWidth = $clog2(NumScratch);

  logic [CsrDataWidth-1:0]    scratch_q [NumScratch];
  logic [CsrDataWidth-1:0]    wr_count_q;
  logic [ScratchIdxWidth-1:0] scratch_idx;
  logic                       wr_ok;
  csr_rsp_t                   rsp_q, rsp_d;

  // Scratch registers sit on consecutive words from 0x000
  assign scratch_idx = csr_req_i.addr[CsrLaneBit +: ScratchIdxWidth];

  always_comb begin
    rsp_d = '0;
    wr_ok = 1'b0;
    if (csr_req_i.req) begin
      rsp_d.rd_ack = ~csr_req_i.wr;
      rsp_d.wr_ack = csr_req_i.wr;
      case (csr_req_i.addr)
        CSR_SCRATCH0, CSR_SCRATCH1, CSR_SCRATCH2, CSR_SCRATCH3: begin
          if (csr_req_i.wr) begin
            wr_ok = 1'b1;
          end else begin
            rsp_d.rd_data = scratch_q[scratch_idx];
          end
        end
        CSR_VERSION: begin
          if (csr_req_i.wr) begin
            rsp_d.err = 1'b1;
          end else begin
            rsp_d.rd_data = CsrVersion;
          end
        end
        CSR_WR_COUNT: begin
          if (csr_req_i.wr) begin
            rsp_d.err = 1'b1;
          end else begin
            rsp_d.rd_data = wr_count_q;
          end
        end
        default: rsp_d.err = 1'b1;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsp_q      <= '0;
      wr_count_q <= '0;
      for (int i = 0; i < NumScratch; i++) begin
        scratch_q[i] <= ScratchReset;
      end
    end else begin
      rsp_q <= rsp_d;
      if (wr_ok) begin
        scratch_q[scratch_idx] <= (scratch_q[scratch_idx] & ~csr_req_i.wr_biten) |
                                  (csr_req_i.wr_data & csr_req_i.wr_biten);
        // Wraps at 32 bits
        wr_count_q <= wr_count_q + 1'b1;
      end
    end
  end

  assign csr_rsp_o = rsp_q;

endmodule

// ==== verif/axi_csr_tb.sv ====
// Testbench for the AXI CSR block with stimulus tasks, register model and checking assertions
`timescale 1ns/1ps

module axi_csr_tb import axi_bus_pkg::*, csr_map_pkg::*;;

  localparam int unsigned Timeout = 50;

  logic                    clk_i;
  logic                    rst_ni;
  logic [AxiAddrWidth-1:0] araddr_i;
  logic [AxiIdWidth-1:0]   arid_i;
  logic [AxiUserWidth-1:0] aruser_i;
  logic                    arvalid_i;
  logic                    arready_o;
  logic [AxiDataWidth-1:0] rdata_o;
  axi_resp_e               rresp_o;
  logic [AxiIdWidth-1:0]   rid_o;
  logic                    rlast_o;
  logic                    rvalid_o;
  logic                    rready_i;
  logic [AxiAddrWidth-1:0] awaddr_i;
  logic [AxiIdWidth-1:0]   awid_i;
  logic [AxiUserWidth-1:0] awuser_i;
  logic                    awvalid_i;
  logic                    awready_o;
  logic [AxiDataWidth-1:0] wdata_i;
  logic [AxiStrbWidth-1:0] wstrb_i;
  logic                    wvalid_i;
  logic                    wready_o;
  axi_resp_e               bresp_o;
  logic [AxiIdWidth-1:0]   bid_o;
  logic                    bvalid_o;
  logic                    bready_i;
  logic                    filter_disable_i;
  logic [AxiUserWidth-1:0] priv_ids_i [NumPrivIds];

  // Reference model and expectations for the transaction in flight
  logic [CsrDataWidth-1:0] model_regs [NumScratch];
  logic [CsrDataWidth-1:0] model_count;
  axi_resp_e               exp_resp;
  logic [AxiDataWidth-1:0] exp_rdata;
  logic [AxiIdWidth-1:0]   exp_id;
  int unsigned             exp_lat;
  logic                    in_flight;
  logic [3:0]              since_hs;
  int unsigned             errors;
  int unsigned             timeouts;

  axi_csr_top UUT (.*);

  always #50 clk_i = ~clk_i;

  // Edges since the last address handshake, for the latency checks
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      since_hs <= '0;
    end else if ((arvalid_i && arready_o) ||
                 (awvalid_i && awready_o && wvalid_i && wready_o)) begin
      since_hs <= 4'd1;
    end else if (since_hs != 4'd0 && since_hs != 4'hF) begin
      since_hs <= since_hs + 4'd1;
    end
  end

  task automatic report_mismatch(input string name, input logic [79:0] exp,
                                 input logic [79:0] got);
    errors++;
    $display("CHECK FAILED %s exp %h got %h", name, exp, got);
  endtask

  task automatic end_run();
    $display("Errors: %0d  timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  endtask

  task automatic timed_out(input string what);
    timeouts++;
    $display("Timeout waiting for %s after %0d cycles", what, Timeout);
  endtask

  rresp_check: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rvalid_o |-> rresp_o == exp_resp)
    else report_mismatch("rresp_o", exp_resp, $sampled(rresp_o));
  rdata_check: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rvalid_o && exp_resp == RESP_OKAY |-> rdata_o == exp_rdata)
    else report_mismatch("rdata_o", exp_rdata, $sampled(rdata_o));
  rid_check: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rvalid_o |-> rid_o == exp_id && rlast_o)
    else report_mismatch("rid_o/rlast_o", {exp_id, 1'b1},
                         {$sampled(rid_o), $sampled(rlast_o)});
  bresp_check: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bvalid_o |-> bresp_o == exp_resp && bid_o == exp_id)
    else report_mismatch("bresp_o/bid_o", {exp_resp, exp_id},
                         {$sampled(bresp_o), $sampled(bid_o)});
  r_stable_check: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rvalid_o && !rready_i |=> rvalid_o && $stable({rdata_o, rresp_o, rid_o}))
    else report_mismatch("rvalid_o/rdata_o/rresp_o/rid_o",
                         {1'b1, $past({rdata_o, rresp_o, rid_o})},
                         {$sampled(rvalid_o), $sampled({rdata_o, rresp_o, rid_o})});
  b_stable_check: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bvalid_o && !bready_i |=> bvalid_o && $stable({bresp_o, bid_o}))
    else report_mismatch("bvalid_o/bresp_o/bid_o", {1'b1, $past({bresp_o, bid_o})},
                         {$sampled(bvalid_o), $sampled({bresp_o, bid_o})});
  busy_check: assert property (@(posedge clk_i) disable iff (!rst_ni)
    in_flight |-> !arready_o && !awready_o && !wready_o)
    else report_mismatch("arready_o/awready_o/wready_o", 3'b000,
                         {$sampled(arready_o), $sampled(awready_o), $sampled(wready_o)});
  r_lat_check: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(rvalid_o) |-> since_hs == exp_lat)
    else report_mismatch("rvalid_o latency", exp_lat, $sampled(since_hs));
  b_lat_check: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(bvalid_o) |-> since_hs == exp_lat)
    else report_mismatch("bvalid_o latency", exp_lat, $sampled(since_hs));

  function automatic logic user_legal(input logic [AxiUserWidth-1:0] user);
    logic hit;
    hit = filter_disable_i;
    for (int i = 0; i < NumPrivIds; i++) begin
      if (user == priv_ids_i[i]) begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

  function automatic logic is_scratch(input logic [11:0] addr);
    return addr[11:4] == 8'h00 && addr[1:0] == 2'b00;
  endfunction

  function automatic logic [31:0] reg_value(input logic [11:0] addr);
    if (is_scratch(addr)) begin
      return model_regs[addr[3:2]];
    end else if (addr == CSR_VERSION) begin
      return CsrVersion;
    end else if (addr == CSR_WR_COUNT) begin
      return model_count;
    end
    return 32'h0;
  endfunction

  // Sampled at the rising edge, left on the falling edge after the handshake
  task automatic wait_ready(input logic is_write);
    int unsigned n;
    n = 0;
    if (timeouts != 0) begin
      return;
    end
    @(posedge clk_i);
    while (is_write ? !(awready_o && wready_o) : !arready_o) begin
      n++;
      if (n > Timeout) begin
        timed_out("address handshake");
        return;
      end
      @(posedge clk_i);
    end
    @(negedge clk_i);
    in_flight = 1'b1;
  endtask

  task automatic wait_response(input logic is_write);
    int unsigned n;
    int unsigned gap;
    n = 0;
    if (timeouts != 0) begin
      return;
    end
    @(posedge clk_i);
    while (is_write ? !bvalid_o : !rvalid_o) begin
      n++;
      if (n > Timeout) begin
        timed_out(is_write ? "write response" : "read response");
        return;
      end
      @(posedge clk_i);
    end
    // Random back-pressure before accepting
    gap = $urandom_range(3, 0);
    repeat (gap) @(posedge clk_i);
    @(negedge clk_i);
    rready_i = !is_write;
    bready_i = is_write;
    @(posedge clk_i);
    @(negedge clk_i);
    rready_i  = 1'b0;
    bready_i  = 1'b0;
    in_flight = 1'b0;
  endtask

  task automatic axi_read(input logic [11:0] addr, input logic [AxiUserWidth-1:0] user);
    logic        legal;
    logic [31:0] value;
    legal     = user_legal(user);
    value     = reg_value(addr);
    exp_id    = 8'($urandom_range(255, 0));
    exp_lat   = legal ? 3 : 2;
    exp_rdata = addr[2] ? {value, 32'h0} : {32'h0, value};
    exp_resp  = (legal && (is_scratch(addr) || addr == CSR_VERSION || addr == CSR_WR_COUNT)) ?
                RESP_OKAY : RESP_SLVERR;
    araddr_i  = {20'h0, addr};
    arid_i    = exp_id;
    aruser_i  = user;
    arvalid_i = 1'b1;
    wait_ready(1'b0);
    arvalid_i = 1'b0;
    wait_response(1'b0);
  endtask

  task automatic axi_write(input logic [11:0] addr, input logic [AxiUserWidth-1:0] user,
                           input logic [63:0] data, input logic [7:0] strb);
    logic        ok;
    logic [31:0] lane_data;
    logic [3:0]  lane_strb;
    logic [31:0] mask;
    ok        = user_legal(user) && is_scratch(addr);
    exp_id    = 8'($urandom_range(255, 0));
    exp_lat   = user_legal(user) ? 3 : 2;
    exp_resp  = ok ? RESP_OKAY : RESP_SLVERR;
    awaddr_i  = {20'h0, addr};
    awid_i    = exp_id;
    awuser_i  = user;
    wdata_i   = data;
    wstrb_i   = strb;
    awvalid_i = 1'b1;
    wvalid_i  = 1'b1;
    wait_ready(1'b1);
    awvalid_i = 1'b0;
    wvalid_i  = 1'b0;
    wait_response(1'b1);
    if (ok) begin
      lane_data = addr[2] ? data[63:32] : data[31:0];
      lane_strb = addr[2] ? strb[7:4] : strb[3:0];
      for (int i = 0; i < 4; i++) begin
        mask[i*8 +: 8] = {8{lane_strb[i]}};
      end
      model_regs[addr[3:2]] = (model_regs[addr[3:2]] & ~mask) | (lane_data & mask);
      model_count++;
    end
  endtask

  function automatic logic [AxiUserWidth-1:0] priv_user();
    return priv_ids_i[$urandom_range(NumPrivIds - 1, 0)];
  endfunction

  initial begin
    logic [AxiUserWidth-1:0] bad_user;
    void'($urandom(36));
    clk_i = 1'b0;
    rst_ni = 1'b0;
    {araddr_i, arid_i, aruser_i, arvalid_i, rready_i} = '0;
    {awaddr_i, awid_i, awuser_i, awvalid_i, wdata_i, wstrb_i, wvalid_i, bready_i} = '0;
    filter_disable_i = 1'b0;
    for (int i = 0; i < NumPrivIds; i++) begin
      priv_ids_i[i] = 32'hA5A5_0000 + i;
      model_regs[i] = ScratchReset;
    end
    model_count = '0;
    exp_resp = RESP_OKAY;
    exp_rdata = '0;
    exp_id = '0;
    exp_lat = 0;
    in_flight = 1'b0;
    errors = 0;
    timeouts = 0;
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);

    reset_check: assert (!rvalid_o && !bvalid_o && arready_o && awready_o)
      else report_mismatch("rvalid_o/bvalid_o/arready_o/awready_o", 4'b0011,
                           {rvalid_o, bvalid_o, arready_o, awready_o});
    for (int i = 0; i < NumScratch; i++) begin
      axi_read(12'(i * 4), priv_user());
    end
    axi_read(CSR_VERSION, priv_user());

    // Random lanes and strobes
    for (int i = 0; i < 24; i++) begin
      axi_write(12'($urandom_range(3, 0) * 4), priv_user(), {$urandom, $urandom},
                8'($urandom_range(255, 0)));
      axi_read(12'($urandom_range(3, 0) * 4), priv_user());
    end

    // ID filtering, then the same requests with the filter off
    bad_user = 32'h0BAD_0000 | $urandom_range(16'hFFFF, 0);
    axi_write(CSR_SCRATCH2, bad_user, {$urandom, $urandom}, 8'hFF);
    axi_read(CSR_SCRATCH2, bad_user);
    axi_read(CSR_SCRATCH2, priv_user());
    filter_disable_i = 1'b1;
    axi_write(CSR_SCRATCH2, bad_user, {$urandom, $urandom}, 8'hFF);
    axi_read(CSR_SCRATCH2, bad_user);
    filter_disable_i = 1'b0;

    // Read-only and unmapped registers
    axi_write(CSR_VERSION, priv_user(), {$urandom, $urandom}, 8'hFF);
    axi_write(CSR_WR_COUNT, priv_user(), {$urandom, $urandom}, 8'hFF);
    axi_write(12'h018, priv_user(), {$urandom, $urandom}, 8'hFF);
    axi_write(12'h002, priv_user(), {$urandom, $urandom}, 8'hFF);
    axi_read(12'h018, priv_user());
    axi_read(12'h100, priv_user());
    axi_read(CSR_WR_COUNT, priv_user());
    axi_read(CSR_VERSION, priv_user());

    repeat (2) @(negedge clk_i);
    end_run();
  end

endmodule
